/* source/scan_pkg.sv */
package scan_pkg;

    // row and column index width, up to 32 by 32
    localparam int IDX_W = 5;

    // address is {row, col}
    localparam int ADDR_W = 2 * IDX_W;
    localparam int MEM_DEPTH = 1 << ADDR_W;

    // unsigned matrix element
    localparam int DATA_W = 16;

    // room for 32 full-scale elements
    localparam int SUM_W = DATA_W + IDX_W;

    // handshake sequencer states
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
    localparam logic [ST_W-1:0] ST_SCAN = 2'd1;
    localparam logic [ST_W-1:0] ST_ACK = 2'd2;

endpackage

/* source/agu.sv */
`timescale 1ns/10ps

module agu #(
    parameter int w = 5
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [w-1:0] ini,
    input  logic [w-1:0] fin,
    input  logic         start,
    input  logic         en,
    output logic [w-1:0] data,
    output logic         last
);

    logic at_fin;

    assign at_fin = (data == fin);

    // final value consumed this cycle
    assign last = at_fin & en;

    always_ff @(posedge clk) begin
        if (rst) begin
            data <= '0;
        end else if (start) begin
            data <= ini;
        end else if (en) begin
            // wrap back so the next pass starts clean
            if (at_fin) begin
                data <= ini;
            end else begin
                data <= data + 1'b1;
            end
        end
    end

endmodule

/* source/get_ctrl.sv */
`timescale 1ns/10ps

module get_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        get_v,
    input  logic [scan_pkg::IDX_W-1:0]  addr_i,
    input  logic [scan_pkg::IDX_W-1:0]  addr_j,
    output logic                        exec,
    output logic                        update,
    output logic [scan_pkg::ADDR_W-1:0] rd_addr,
    output logic [scan_pkg::IDX_W-1:0]  row,
    output logic                        get_fin
);

    import scan_pkg::*;

    logic [IDX_W-1:0] i;
    logic [IDX_W-1:0] j;
    logic             row_last;
    logic             last_update;
    logic             fin_d1;
    logic             fin_d2;

    // column counter, one step per read
    agu #(
        .w(IDX_W)
    ) agu_get_j (
        .clk   (clk),
        .rst   (rst),
        .ini   ('0),
        .fin   (addr_j),
        .start (get_v),
        .en    (exec),
        .data  (j),
        .last  (update)
    );

    // row counter, steps at each row end
    agu #(
        .w(IDX_W)
    ) agu_get_i (
        .clk   (clk),
        .rst   (rst),
        .ini   ('0),
        .fin   (addr_i),
        .start (get_v),
        .en    (update),
        .data  (i),
        .last  (row_last)
    );

    // last column of the last row
    assign last_update = update & row_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            exec <= 1'b0;
        end else if (get_v) begin
            exec <= 1'b1;
        end else if (last_update) begin
            exec <= 1'b0;
        end
    end

    // memory read then accumulator output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            fin_d1 <= 1'b0;
            fin_d2 <= 1'b0;
            get_fin <= 1'b0;
        end else begin
            fin_d1 <= last_update;
            fin_d2 <= fin_d1;
            get_fin <= fin_d2;
        end
    end

    assign rd_addr = {i, j};
    assign row = i;

endmodule

/* source/tile_mem.sv */
`timescale 1ns/10ps

module tile_mem (
    input  logic                        clk,
    input  logic                        wr_en,
    input  logic [scan_pkg::ADDR_W-1:0] wr_addr,
    input  logic [scan_pkg::DATA_W-1:0] wr_data,
    input  logic [scan_pkg::ADDR_W-1:0] rd_addr,
    output logic [scan_pkg::DATA_W-1:0] rd_data
);

    import scan_pkg::*;

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    // host load port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data one cycle after address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* source/row_accum.sv */
`timescale 1ns/10ps

module row_accum (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       exec,
    input  logic                       update,
    input  logic [scan_pkg::IDX_W-1:0] row,
    input  logic [scan_pkg::DATA_W-1:0] rd_data,
    output logic [scan_pkg::SUM_W-1:0] row_sum,
    output logic [scan_pkg::IDX_W-1:0] row_idx,
    output logic                       row_valid
);

    import scan_pkg::*;

    logic             exec_d;
    logic             update_d;
    logic [IDX_W-1:0] row_d;
    logic [SUM_W-1:0] acc;
    logic [SUM_W-1:0] sum_next;

    // line up control with the memory read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_d <= 1'b0;
            update_d <= 1'b0;
        end else begin
            exec_d <= exec;
            update_d <= update;
        end
    end

    always_ff @(posedge clk) begin
        row_d <= row;
    end

    assign sum_next = acc + SUM_W'(rd_data);

    // running sum, cleared after the last column
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (exec_d) begin
            acc <= update_d ? '0 : sum_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            row_valid <= 1'b0;
        end else begin
            row_valid <= exec_d & update_d;
        end
    end

    // completed row
    always_ff @(posedge clk) begin
        if (exec_d & update_d) begin
            row_sum <= sum_next;
            row_idx <= row_d;
        end
    end

endmodule

/* source/host_handshake.sv */
`timescale 1ns/10ps

module host_handshake (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  logic [scan_pkg::IDX_W-1:0] last_row,
    input  logic [scan_pkg::IDX_W-1:0] last_col,
    input  logic                       get_fin,
    output logic                       ack,
    output logic                       busy,
    output logic                       get_v,
    output logic [scan_pkg::IDX_W-1:0] addr_i,
    output logic [scan_pkg::IDX_W-1:0] addr_j
);

    import scan_pkg::*;

    logic [ST_W-1:0] state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            ack <= 1'b0;
            busy <= 1'b0;
            get_v <= 1'b0;
        end else begin
            get_v <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // new command
                    if (req) begin
                        state <= ST_SCAN;
                        busy <= 1'b1;
                        get_v <= 1'b1;
                    end
                end
                ST_SCAN: begin
                    if (get_fin) begin
                        state <= ST_ACK;
                        ack <= 1'b1;
                    end
                end
                ST_ACK: begin
                    // hold ack until the host lets go
                    if (!req) begin
                        state <= ST_IDLE;
                        ack <= 1'b0;
                        busy <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // size captured on acceptance
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            addr_i <= last_row;
            addr_j <= last_col;
        end
    end

endmodule

/* source/scan_top.sv */
`timescale 1ns/10ps

module scan_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_en,
    input  logic [scan_pkg::ADDR_W-1:0] wr_addr,
    input  logic [scan_pkg::DATA_W-1:0] wr_data,
    input  logic                        req,
    input  logic [scan_pkg::IDX_W-1:0]  last_row,
    input  logic [scan_pkg::IDX_W-1:0]  last_col,
    output logic                        ack,
    output logic                        busy,
    output logic [scan_pkg::SUM_W-1:0]  row_sum,
    output logic [scan_pkg::IDX_W-1:0]  row_idx,
    output logic                        row_valid
);

    import scan_pkg::*;

    logic              get_v;
    logic [IDX_W-1:0]  addr_i;
    logic [IDX_W-1:0]  addr_j;
    logic              get_fin;
    logic              exec;
    logic              update;
    logic [ADDR_W-1:0] rd_addr;
    logic [IDX_W-1:0]  row;
    logic [DATA_W-1:0] rd_data;

    host_handshake u_host_handshake (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .last_row (last_row),
        .last_col (last_col),
        .get_fin  (get_fin),
        .ack      (ack),
        .busy     (busy),
        .get_v    (get_v),
        .addr_i   (addr_i),
        .addr_j   (addr_j)
    );

    get_ctrl u_get_ctrl (
        .clk     (clk),
        .rst     (rst),
        .get_v   (get_v),
        .addr_i  (addr_i),
        .addr_j  (addr_j),
        .exec    (exec),
        .update  (update),
        .rd_addr (rd_addr),
        .row     (row),
        .get_fin (get_fin)
    );

    tile_mem u_tile_mem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    row_accum u_row_accum (
        .clk       (clk),
        .rst       (rst),
        .exec      (exec),
        .update    (update),
        .row       (row),
        .rd_data   (rd_data),
        .row_sum   (row_sum),
        .row_idx   (row_idx),
        .row_valid (row_valid)
    );

endmodule

/* test/scan_model.svh */
`ifndef SCAN_MODEL_SVH
`define SCAN_MODEL_SVH

// galois lfsr, polynomial x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'hf71066c9;

// host view of the buffer, one entry per word written
logic [DATA_W-1:0] ref_mem [MEM_DEPTH];

// one lfsr step for every bit handed out
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        bit_out;
    value = '0;
    for (int k = 0; k < n; k++) begin
        bit_out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (bit_out) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        value = {value[30:0], bit_out};
    end
    return value;
endfunction

function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                    input logic [DATA_W-1:0] data);
    ref_mem[addr] = data;
endfunction

// plain unsigned sum of columns 0 to last_c of one row
function automatic logic [SUM_W-1:0] expected_row_sum(input int row_n, input int last_c);
    logic [SUM_W-1:0]  total;
    logic [ADDR_W-1:0] addr;
    total = '0;
    for (int c = 0; c <= last_c; c++) begin
        // row in the upper half, column in the lower half
        addr = {IDX_W'(row_n), IDX_W'(c)};
        total = total + SUM_W'(ref_mem[addr]);
    end
    return total;
endfunction

`endif

/* test/scan_tb.sv */
`timescale 1ns/10ps

module scan_tb;

    import scan_pkg::*;

    logic              clk = 1'b0;
    logic              rst;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic              req;
    logic [IDX_W-1:0]  last_row;
    logic [IDX_W-1:0]  last_col;
    logic              ack;
    logic              busy;
    logic [SUM_W-1:0]  row_sum;
    logic [IDX_W-1:0]  row_idx;
    logic              row_valid;

    int   errors = 0;
    int   timeouts = 0;
    int   commands = 0;
    logic aborted = 1'b0;

    `include "scan_model.svh"

    scan_top uut (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .req       (req),
        .last_row  (last_row),
        .last_col  (last_col),
        .ack       (ack),
        .busy      (busy),
        .row_sum   (row_sum),
        .row_idx   (row_idx),
        .row_valid (row_valid)
    );

    always #4 clk = ~clk;

    // inputs change and outputs are sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("[FAIL] %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
    endtask

    task automatic check_quiet(input string name);
        if (ack !== 1'b0)
            report_mismatch({name, " ack"}, 0, 32'(ack));
        if (busy !== 1'b0)
            report_mismatch({name, " busy"}, 0, 32'(busy));
        if (row_valid !== 1'b0)
            report_mismatch({name, " row_valid"}, 0, 32'(row_valid));
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        wr_en = 1'b1;
        wr_addr = addr;
        wr_data = data;
        model_write(addr, data);
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic fill_region(input int lr, input int lc, input logic all_ones);
        logic [DATA_W-1:0] value;
        for (int r = 0; r <= lr; r++) begin
            for (int c = 0; c <= lc; c++) begin
                value = all_ones ? '1 : DATA_W'(rand_bits(DATA_W));
                write_word({IDX_W'(r), IDX_W'(c)}, value);
            end
        end
    endtask

    // a few words inside the next scan area
    task automatic rewrite_in_region(input int lr, input int lc, input int count);
        int                r;
        int                c;
        logic [DATA_W-1:0] value;
        for (int k = 0; k < count; k++) begin
            r = int'(rand_bits(IDX_W)) % (lr + 1);
            c = int'(rand_bits(IDX_W)) % (lc + 1);
            value = DATA_W'(rand_bits(DATA_W));
            write_word({IDX_W'(r), IDX_W'(c)}, value);
        end
    endtask

    task automatic run_command(input int lr, input int lc);
        int               rows_seen;
        int               cycles;
        int               last_valid;
        int               limit;
        int               hold;
        logic [SUM_W-1:0] exp_sum;
        if (aborted)
            return;
        rows_seen = 0;
        cycles = 0;
        last_valid = 0;
        limit = (lr + 1) * (lc + 1) + 16;
        commands++;
        req = 1'b1;
        last_row = IDX_W'(lr);
        last_col = IDX_W'(lc);
        next_cycle();
        while (ack !== 1'b1 && cycles < limit) begin
            if (busy !== 1'b1)
                report_mismatch("busy during scan", 1, 32'(busy));
            if (row_valid === 1'b1) begin
                if (rows_seen > lr) begin
                    errors++;
                    $display("extra row_valid pulse after the last row %0d", lr);
                end else begin
                    exp_sum = expected_row_sum(rows_seen, lc);
                    if (row_idx !== IDX_W'(rows_seen))
                        report_mismatch("row order", 32'(rows_seen), 32'(row_idx));
                    if (row_sum !== exp_sum)
                        report_mismatch("row sum", 32'(exp_sum), 32'(row_sum));
                end
                rows_seen++;
                last_valid = cycles;
            end
            next_cycle();
            cycles++;
        end
        if (ack !== 1'b1) begin
            timeouts++;
            aborted = 1'b1;
            req = 1'b0;
            $display("timeout: ack did not rise within %0d cycles of req", limit);
            return;
        end
        if (rows_seen != lr + 1)
            report_mismatch("row count", 32'(lr + 1), 32'(rows_seen));
        // get_fin one cycle after the final row, then ack
        if (cycles - last_valid != 2)
            report_mismatch("ack after last row", 2, 32'(cycles - last_valid));
        hold = int'(rand_bits(2));
        for (int k = 0; k < hold; k++) begin
            next_cycle();
            if (ack !== 1'b1)
                report_mismatch("ack hold", 1, 32'(ack));
            if (busy !== 1'b1)
                report_mismatch("busy hold", 1, 32'(busy));
            if (row_valid !== 1'b0)
                report_mismatch("row_valid after ack", 0, 32'(row_valid));
        end
        req = 1'b0;
        cycles = 0;
        while (ack === 1'b1 && cycles < 8) begin
            next_cycle();
            cycles++;
        end
        if (ack === 1'b1) begin
            timeouts++;
            aborted = 1'b1;
            $display("timeout: ack stayed high after req dropped");
            return;
        end
        if (cycles != 1)
            report_mismatch("ack fall latency", 1, 32'(cycles));
        if (busy !== 1'b0)
            report_mismatch("busy after ack", 0, 32'(busy));
    endtask

    initial begin
        int lr;
        int lc;
        rst = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        req = 1'b0;
        last_row = '0;
        last_col = '0;
        for (int k = 0; k < 16; k++) begin
            next_cycle();
            check_quiet("reset");
        end
        rst = 1'b0;
        next_cycle();
        check_quiet("after reset");

        // whole buffer known before any scan
        fill_region(31, 31, 1'b0);
        run_command(0, 0);
        // largest possible row sum
        fill_region(0, 31, 1'b1);
        run_command(0, 31);
        run_command(31, 0);
        run_command(31, 31);

        for (int n = 0; n < 6; n++) begin
            lr = int'(rand_bits(IDX_W));
            lc = int'(rand_bits(IDX_W));
            fill_region(lr, lc, 1'b0);
            run_command(lr, lc);
        end

        // back to back, small rewrites in between
        for (int n = 0; n < 6; n++) begin
            lr = int'(rand_bits(IDX_W));
            lc = int'(rand_bits(IDX_W));
            rewrite_in_region(lr, lc, 1 + int'(rand_bits(4)));
            run_command(lr, lc);
        end

        $display("commands: %0d  errors: %0d  timeouts: %0d", commands, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+test
source/scan_pkg.sv
source/agu.sv
source/get_ctrl.sv
source/tile_mem.sv
source/row_accum.sv
source/host_handshake.sv
source/scan_top.sv
test/scan_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps -f src.f --top-module scan_tb -o scan_sim
	@out="$$(./obj_dir/scan_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
